// ==== decode_pkg.sv ====
// Decode stage shared definitions
`default_nettype none

package decode_pkg;

    localparam int DATA_W      = 16;               // Operand width
    localparam int REG_N       = 16;               // Register count
    localparam int REG_W       = $clog2(REG_N);    // Register index width
    localparam int FETCH_DEPTH = 4;                // Queue entries, also initial fetch credits
    localparam int EX_CREDITS  = 2;                // Credits granted by execute at reset
    localparam int PTR_W       = $clog2(FETCH_DEPTH);
    localparam int CNT_W       = $clog2(FETCH_DEPTH + 1);
    localparam int CRED_W      = $clog2(EX_CREDITS + 1);

    localparam logic [REG_W-1:0]  SP_REG   = 4'd15;   // Stack pointer
    localparam logic [REG_W-1:0]  DS_REG   = 4'd14;   // Data segment
    localparam logic [DATA_W-1:0] SP_RESET = '1;      // SP after reset

    // ALU operation codes sent to execute
    localparam logic [2:0] ALU_ADD = 3'd0;
    localparam logic [2:0] ALU_SUB = 3'd1;
    localparam logic [2:0] ALU_AND = 3'd2;
    localparam logic [2:0] ALU_OR  = 3'd3;

    // Instruction opcode, bits 15:12
    typedef enum logic [3:0] {
        OP_ADD  = 4'h0,
        OP_SUB  = 4'h1,
        OP_AND  = 4'h2,
        OP_OR   = 4'h3,
        OP_ADDI = 4'h4,   // 4-bit imm in [3:0]
        OP_LW   = 4'h5,   // Reg [11:8], imm [7:0], base DS
        OP_SW   = 4'h6,
        OP_BR   = 4'h7,   // Cond [10:8], offset [7:0]
        OP_CALL = 4'h8,   // Target [11:0]
        OP_RET  = 4'h9,
        OP_NOP  = 4'hF
    } opcode_e;

    // Control fields, 10 bits
    typedef struct packed {
        logic       reg_write;
        logic       mem_to_reg;   // Load
        logic       reg_to_mem;   // Save
        logic       alu_src;      // Immediate as operand 2
        logic [2:0] alu_op;
        logic       branch;
        logic       call;
        logic       ret;
    } ctrl_t;

    // Bundle handed to execute
    typedef struct packed {
        ctrl_t             ctrl;
        logic [DATA_W-1:0] read_data_1;
        logic [DATA_W-1:0] read_data_2;
        logic [DATA_W-1:0] sign_ext;
        logic [REG_W-1:0]  dest_reg;
        logic [2:0]        branch_cond;
        logic [11:0]       call_target;
        logic [DATA_W-1:0] pc;
    } decoded_t;

    // Fetched instruction
    typedef struct packed {
        logic [15:0]       instr;
        logic [DATA_W-1:0] pc;
    } fetch_t;

    // Writeback port
    typedef struct packed {
        logic              valid;
        logic [REG_W-1:0]  idx;
        logic [DATA_W-1:0] data;
    } wb_t;

endpackage

`default_nettype wire

// ==== fetch_queue.sv ====
// Fetch instruction queue
`timescale 1ns/100ps
`default_nettype none

module fetch_queue (
    input  logic               clk,
    input  logic               rst,
    input  logic               fetch_valid,   // Fetch holds a credit when this is high
    input  decode_pkg::fetch_t fetch,
    input  logic               pop,
    output logic               head_valid,
    output decode_pkg::fetch_t head,
    output logic               fetch_credit   // One credit back per pop
);
    import decode_pkg::*;

    fetch_t           mem [FETCH_DEPTH];   // Circular buffer
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;               // Occupancy

    // Pointer advance with wrap
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(FETCH_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign head_valid = (count != '0);
    assign head       = mem[rd_ptr];   // Oldest entry

    // Payload storage
    always_ff @(posedge clk) begin
        if (fetch_valid) begin
            mem[wr_ptr] <= fetch;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            fetch_credit <= 1'b0;
        end else begin
            if (fetch_valid) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({fetch_valid, pop})
                2'b10:   count <= count + 1'b1;   // Push only
                2'b01:   count <= count - 1'b1;   // Pop only
                default: count <= count;          // Both or neither
            endcase
            fetch_credit <= pop;   // Pulses the cycle after the pop
        end
    end

endmodule

`default_nettype wire

// ==== control_decoder.sv ====
// Opcode control decoder
`timescale 1ns/100ps
`default_nettype none

module control_decoder (
    input  decode_pkg::opcode_e opcode,
    output decode_pkg::ctrl_t   ctrl,
    output logic                data_reg,      // Read port 1 from DS
    output logic                stack_reg,     // Read port 1 from SP
    output logic                rt_src,        // Read reg 2 from [11:8]
    output logic                sign_ext_sel   // 1 = 8-bit L/S imm
);
    import decode_pkg::*;

    always_comb begin
        ctrl         = '0;   // NOP unless decoded below
        data_reg     = 1'b0;
        stack_reg    = 1'b0;
        rt_src       = 1'b0;
        sign_ext_sel = 1'b0;
        case (opcode)
            OP_ADD: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_ADD;
            end
            OP_SUB: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_SUB;
            end
            OP_AND: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_AND;
            end
            OP_OR: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_op    = ALU_OR;
            end
            OP_ADDI: begin
                ctrl.reg_write = 1'b1;
                ctrl.alu_src   = 1'b1;      // 4-bit imm
                ctrl.alu_op    = ALU_ADD;
            end
            OP_LW: begin
                ctrl.reg_write  = 1'b1;
                ctrl.mem_to_reg = 1'b1;
                ctrl.alu_src    = 1'b1;     // DS + imm
                ctrl.alu_op     = ALU_ADD;
                data_reg        = 1'b1;
                sign_ext_sel    = 1'b1;
            end
            OP_SW: begin
                ctrl.reg_to_mem = 1'b1;
                ctrl.alu_src    = 1'b1;
                ctrl.alu_op     = ALU_ADD;
                data_reg        = 1'b1;
                rt_src          = 1'b1;     // Store data from [11:8]
                sign_ext_sel    = 1'b1;
            end
            OP_BR: begin
                ctrl.branch = 1'b1;
            end
            OP_CALL: begin
                ctrl.call   = 1'b1;
                ctrl.alu_op = ALU_SUB;      // SP decrement
                stack_reg   = 1'b1;
            end
            OP_RET: begin
                ctrl.ret    = 1'b1;
                ctrl.alu_op = ALU_ADD;      // SP increment
                stack_reg   = 1'b1;
            end
            default: begin
                ctrl = '0;                  // OP_NOP and undefined codes
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== register_file.sv ====
// 16x16 register file
`timescale 1ns/100ps
`default_nettype none

module register_file (
    input  logic             clk,
    input  logic             rst,
    input  decode_pkg::wb_t  wb,
    input  logic [3:0]       rs,
    input  logic [3:0]       rt,
    input  logic             data_reg,
    input  logic             stack_reg,
    output logic [15:0]      read_data_1,
    output logic [15:0]      read_data_2
);
    import decode_pkg::*;

    logic [DATA_W-1:0] regs [REG_N];

    // Write port, SP comes out of reset at SP_RESET
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < REG_N; i++) begin
                regs[i] <= '0;
            end
            regs[SP_REG] <= SP_RESET;
        end else if (wb.valid) begin
            regs[wb.idx] <= wb.data;
        end
    end

    // Port 1 may be forced to a fixed register
    always_comb begin
        if (data_reg) begin
            read_data_1 = regs[DS_REG];   // Load/save base
        end else if (stack_reg) begin
            read_data_1 = regs[SP_REG];   // Call/ret
        end else begin
            read_data_1 = regs[rs];
        end
    end

    assign read_data_2 = regs[rt];

endmodule

`default_nettype wire

// ==== hazard_scoreboard.sv ====
// Pending-write scoreboard
`timescale 1ns/100ps
`default_nettype none

module hazard_scoreboard (
    input  logic            clk,
    input  logic            rst,
    input  logic [3:0]      rs,            // Effective read reg 1
    input  logic [3:0]      rt,
    input  logic            uses_rs,
    input  logic            uses_rt,
    input  logic [3:0]      dest,
    input  logic            writes_dest,
    input  logic            issue,
    input  decode_pkg::wb_t wb,
    output logic            hazard
);
    import decode_pkg::*;

    logic [REG_N-1:0] pending;   // One bit per register

    always_ff @(posedge clk) begin
        if (rst) begin
            pending <= '0;
        end else begin
            if (wb.valid) begin
                pending[wb.idx] <= 1'b0;   // Write completed
            end
            // Later assignment wins on the same index
            if (issue && writes_dest) begin
                pending[dest] <= 1'b1;
            end
        end
    end

    // RAW on either source, WAW on dest
    assign hazard = (uses_rs && pending[rs])
                 || (uses_rt && pending[rt])
                 || (writes_dest && pending[dest]);

endmodule

`default_nettype wire

// ==== issue_stage.sv ====
// Decode and issue logic
`timescale 1ns/100ps
`default_nettype none

module issue_stage (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 head_valid,
    input  decode_pkg::fetch_t   head,
    input  logic                 credit_avail,   // Execute can take a bundle
    input  decode_pkg::wb_t      wb,
    output logic                 pop,
    output logic                 issue_valid,
    output decode_pkg::decoded_t issued
);
    import decode_pkg::*;

    opcode_e          opcode;
    ctrl_t            ctrl;
    logic             data_reg;
    logic             stack_reg;
    logic             rt_src;
    logic             sign_ext_sel;
    logic [REG_W-1:0] rs;
    logic [REG_W-1:0] rt;
    logic [REG_W-1:0] ls_reg;       // Dest, also SW data reg
    logic [REG_W-1:0] rs_eff;       // What port 1 really reads
    logic             uses_rs;
    logic             uses_rt;
    logic             hazard;
    logic             go;
    logic [DATA_W-1:0] rd1;
    logic [DATA_W-1:0] rd2;
    logic [DATA_W-1:0] imm;

    // Instruction fields
    assign opcode = opcode_e'(head.instr[15:12]);
    assign ls_reg = head.instr[11:8];
    assign rs     = head.instr[7:4];
    assign rt     = rt_src ? ls_reg : head.instr[3:0];   // SW stores [11:8]

    assign rs_eff = data_reg ? DS_REG : (stack_reg ? SP_REG : rs);

    // Source use follows from the control fields
    assign uses_rs = ctrl.reg_write || ctrl.reg_to_mem || ctrl.call || ctrl.ret;
    assign uses_rt = (ctrl.reg_write && !ctrl.alu_src) || ctrl.reg_to_mem;

    // Sign extension of the selected immediate
    assign imm = sign_ext_sel ? {{8{head.instr[7]}}, head.instr[7:0]}
                              : {{12{head.instr[3]}}, head.instr[3:0]};

    control_decoder control_decoder_inst (
        .opcode       (opcode),
        .ctrl         (ctrl),
        .data_reg     (data_reg),
        .stack_reg    (stack_reg),
        .rt_src       (rt_src),
        .sign_ext_sel (sign_ext_sel)
    );

    register_file register_file_inst (
        .clk         (clk),
        .rst         (rst),
        .wb          (wb),
        .rs          (rs),
        .rt          (rt),
        .data_reg    (data_reg),
        .stack_reg   (stack_reg),
        .read_data_1 (rd1),
        .read_data_2 (rd2)
    );

    hazard_scoreboard hazard_scoreboard_inst (
        .clk         (clk),
        .rst         (rst),
        .rs          (rs_eff),
        .rt          (rt),
        .uses_rs     (uses_rs),
        .uses_rt     (uses_rt),
        .dest        (ls_reg),
        .writes_dest (ctrl.reg_write),
        .issue       (go),
        .wb          (wb),
        .hazard      (hazard)
    );

    // Head waits in the queue until it can go
    assign go          = head_valid && !hazard && credit_avail;
    assign pop         = go;
    assign issue_valid = go;

    always_comb begin
        issued.ctrl        = ctrl;
        issued.read_data_1 = rd1;
        issued.read_data_2 = rd2;
        issued.sign_ext    = imm;
        issued.dest_reg    = ls_reg;
        issued.branch_cond = head.instr[10:8];
        issued.call_target = head.instr[11:0];
        issued.pc          = head.pc;
    end

endmodule

`default_nettype wire

// ==== ex_credit_port.sv ====
// Execute-side output register
`timescale 1ns/100ps
`default_nettype none

module ex_credit_port (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 issue_valid,
    input  decode_pkg::decoded_t issued,
    input  logic                 ex_credit,      // One credit back from execute
    output logic                 credit_avail,
    output logic                 out_valid,
    output decode_pkg::decoded_t out
);
    import decode_pkg::*;

    logic [CRED_W-1:0] credits;   // Free slots downstream

    assign credit_avail = (credits != '0);

    // Bundle register, only loaded on issue
    always_ff @(posedge clk) begin
        if (issue_valid) begin
            out <= issued;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            credits   <= CRED_W'(EX_CREDITS);
        end else begin
            out_valid <= issue_valid;   // One cycle after issue
            case ({issue_valid, ex_credit})
                2'b10:   credits <= credits - 1'b1;
                2'b01:   credits <= credits + 1'b1;
                default: credits <= credits;   // Both cancel
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== decode_top.sv ====
// Decode stage top level
`timescale 1ns/100ps
`default_nettype none

module decode_top (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 fetch_valid,
    input  decode_pkg::fetch_t   fetch,
    output logic                 fetch_credit,
    input  decode_pkg::wb_t      wb,
    input  logic                 ex_credit,
    output logic                 out_valid,
    output decode_pkg::decoded_t out
);
    import decode_pkg::*;

    logic     head_valid;
    fetch_t   head;
    logic     pop;
    logic     credit_avail;
    logic     issue_valid;
    decoded_t issued;

    fetch_queue fetch_queue_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .pop          (pop),
        .head_valid   (head_valid),
        .head         (head),
        .fetch_credit (fetch_credit)
    );

    issue_stage issue_stage_inst (
        .clk          (clk),
        .rst          (rst),
        .head_valid   (head_valid),
        .head         (head),
        .credit_avail (credit_avail),
        .wb           (wb),
        .pop          (pop),
        .issue_valid  (issue_valid),
        .issued       (issued)
    );

    ex_credit_port ex_credit_port_inst (
        .clk          (clk),
        .rst          (rst),
        .issue_valid  (issue_valid),
        .issued       (issued),
        .ex_credit    (ex_credit),
        .credit_avail (credit_avail),
        .out_valid    (out_valid),
        .out          (out)
    );

endmodule

`default_nettype wire

// ==== tb_decode.sv ====
// Decode stage testbench
`timescale 1ns/100ps
`default_nettype none

module tb_decode;
    import decode_pkg::*;

    logic        clk;
    logic        rst;
    logic        fetch_valid;
    fetch_t      fetch;
    logic        fetch_credit;
    wb_t         wb;
    logic        ex_credit;
    logic        out_valid;
    decoded_t    out;

    logic [31:0] stim [512];              // Raw tokens from the stim file
    decoded_t    exp_q [$];               // Expected bundles in order
    int          sent           = 0;      // Instructions pushed
    int          pulses         = 0;      // fetch_credit pulses seen
    int          out_count      = 0;
    int          returned       = 0;      // Credits given back to DUT
    int          exp_total      = 0;
    int          timeout_cycles = 400;    // Per wait loop

    decode_top decode_top_inst (
        .clk          (clk),
        .rst          (rst),
        .fetch_valid  (fetch_valid),
        .fetch        (fetch),
        .fetch_credit (fetch_credit),
        .wb           (wb),
        .ex_credit    (ex_credit),
        .out_valid    (out_valid),
        .out          (out)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic stop_with_error(input string why);
        $display("%s", why);
        $display("Regression failed");
        $fatal(1, "stopping after first error");
    endtask

    task automatic compare_value(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
        if (got !== exp) begin
            stop_with_error($sformatf("mismatch at %0t: %s got %0h expected %0h",
                                      $time, what, got, exp));
        end
    endtask

    task automatic compare_bundle(input decoded_t got, input decoded_t exp);
        string tag;
        tag = $sformatf("pc %h", exp.pc);
        compare_value({tag, " ctrl"}, 32'(got.ctrl), 32'(exp.ctrl));
        compare_value({tag, " read_data_1"}, 32'(got.read_data_1), 32'(exp.read_data_1));
        compare_value({tag, " read_data_2"}, 32'(got.read_data_2), 32'(exp.read_data_2));
        compare_value({tag, " sign_ext"}, 32'(got.sign_ext), 32'(exp.sign_ext));
        compare_value({tag, " dest_reg"}, 32'(got.dest_reg), 32'(exp.dest_reg));
        compare_value({tag, " branch_cond"}, 32'(got.branch_cond), 32'(exp.branch_cond));
        compare_value({tag, " call_target"}, 32'(got.call_target), 32'(exp.call_target));
        compare_value({tag, " pc"}, 32'(got.pc), 32'(exp.pc));   // Catches reordering
    endtask

    // Counters are only read after a rising edge
    task automatic wait_for_outputs(input int n);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (out_count < n) begin
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_with_error($sformatf("timeout waiting for output number %0d", n));
            end
        end
    endtask

    task automatic push_instruction(input logic [15:0] word, input logic [15:0] pc);
        int cycles;
        cycles = 0;
        @(posedge clk);
        while (FETCH_DEPTH - sent + pulses <= 0) begin   // Out of fetch credits
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_with_error("timeout waiting for a fetch credit");
            end
        end
        @(negedge clk);
        fetch_valid = 1'b1;
        fetch.instr = word;
        fetch.pc    = pc;
        sent++;
        @(negedge clk);
        fetch_valid = 1'b0;
    endtask

    // Waits for n outputs, checks nothing more leaks out, then writes
    task automatic apply_writeback(input logic [3:0] idx, input logic [15:0] data,
                                   input int n);
        wait_for_outputs(n);
        repeat (4) @(posedge clk);
        compare_value("outputs before writeback", 32'(out_count), 32'(n));
        @(negedge clk);
        wb.valid = 1'b1;
        wb.idx   = idx;
        wb.data  = data;
        @(negedge clk);
        wb.valid = 1'b0;
    endtask

    // Output checks and downstream credit return
    initial begin : output_monitor
        decoded_t e;
        int       gap;
        void'($urandom(40074));   // Credit gaps drawn in this process
        gap       = 0;
        ex_credit = 1'b0;
        forever begin
            @(negedge clk);
            ex_credit = 1'b0;
            if (!rst) begin
                if (fetch_credit) begin
                    pulses++;
                end
                if (out_valid) begin
                    out_count++;
                    compare_value("outputs within credits",
                                  32'(out_count <= EX_CREDITS + returned), 32'd1);
                    if (exp_q.size() == 0) begin
                        stop_with_error("output bundle with none expected");
                    end else begin
                        e = exp_q.pop_front();
                        compare_bundle(out, e);
                    end
                end
                if (gap > 0) begin
                    gap--;                          // Execute still busy
                end else if (out_count > returned) begin
                    ex_credit = 1'b1;
                    returned++;
                    gap = int'($urandom % 4);
                end
            end
        end
    end

    initial begin : stimulus
        decoded_t e;
        int       i;
        int       cycles;
        rst         = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        wb          = '0;
        $readmemh("decode_stim.txt", stim);

        // First pass collects the expected bundles
        i = 0;
        while (stim[i] !== 32'd0) begin
            if (i > 500) begin
                stop_with_error("stimulus file has no end record");
            end else if (stim[i] === 32'd1) begin
                i += 3;
            end else if (stim[i] === 32'd2) begin
                i += 4;
            end else if (stim[i] === 32'd3) begin
                e.ctrl        = ctrl_t'(stim[i+1][9:0]);
                e.read_data_1 = stim[i+2][15:0];
                e.read_data_2 = stim[i+3][15:0];
                e.sign_ext    = stim[i+4][15:0];
                e.dest_reg    = stim[i+5][3:0];
                e.branch_cond = stim[i+6][2:0];
                e.call_target = stim[i+7][11:0];
                e.pc          = stim[i+8][15:0];
                exp_q.push_back(e);
                i += 9;
            end else begin
                stop_with_error($sformatf("bad record kind at token %0d of stim file", i));
            end
        end
        exp_total = exp_q.size();
        if (exp_total == 0) begin
            stop_with_error("no expected bundles in stim file");
        end

        repeat (16) @(negedge clk);
        rst = 1'b0;
        compare_value("out_valid after reset", 32'(out_valid), 32'd0);

        // Second pass drives fetch and writeback in file order
        i = 0;
        while (stim[i] !== 32'd0) begin
            if (stim[i] === 32'd1) begin
                push_instruction(stim[i+1][15:0], stim[i+2][15:0]);
                i += 3;
            end else if (stim[i] === 32'd2) begin
                apply_writeback(stim[i+1][3:0], stim[i+2][15:0], int'(stim[i+3]));
                i += 4;
            end else begin
                i += 9;
            end
        end

        wait_for_outputs(exp_total);
        cycles = 0;
        while (pulses != sent) begin   // Last credits still on their way
            @(posedge clk);
            cycles++;
            if (cycles > timeout_cycles) begin
                stop_with_error("timeout waiting for fetch credits to return");
            end
        end
        repeat (4) @(posedge clk);
        compare_value("fetch credit pulses", 32'(pulses), 32'(sent));
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
decode_pkg.sv
fetch_queue.sv
control_decoder.sv
register_file.sv
hazard_scoreboard.sv
issue_stage.sv
ex_credit_port.sv
decode_top.sv
tb_decode.sv

// ==== Makefile ====
# Verilator build and regression for the decode stage

VERILATOR ?= verilator
TOP       ?= tb_decode
FILELIST  ?= list.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_MSG  ?= Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

$(OBJ_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(OBJ_DIR)

test: $(OBJ_DIR)/V$(TOP)
	@out=$$(./$(OBJ_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -q "^$(PASS_MSG)$$"

clean:
	rm -rf $(OBJ_DIR)

// ==== decode_stim.txt ====
// Kind 1 instr: word pc | kind 2 writeback: reg data outputs_before | kind 0 end
// Kind 3 expected: ctrl rd1 rd2 sign_ext dest cond call_target pc
2 1 0011 0   // Preload r1
2 2 0022 0   // Preload r2
2 E 1000 0   // Data segment base
1 9000 0100  // RET first, sees SP reset value
1 8ABC 0101  // CALL, negative 4-bit field
1 0312 0102  // ADD r3
1 1421 0103  // SUB r4
1 2512 0104  // AND r5
1 3612 0105  // OR r6
1 471D 0106  // ADDI r7, imm -3
1 58F0 0107  // LW r8, imm -16
1 6205 0108  // SW r2
1 7580 0109  // BR cond 5
1 F000 010A  // NOP
1 A123 010B  // Undefined opcode
1 0934 010C  // ADD r9 = r3 + r4, held
1 4A91 010D  // ADDI r10 from r9, held
2 3 0100 C   // r3 write, r4 still pending
2 4 0200 C
2 9 0300 D
1 4A12 010E  // Second write of r10, held
2 A 0400 E
3 001 FFFF 0000 0000 0 0 000 0100
3 00A FFFF 0000 FFFC A 2 ABC 0101
3 200 0011 0022 0002 3 3 312 0102
3 208 0022 0011 0001 4 4 421 0103
3 210 0011 0022 0002 5 5 512 0104
3 218 0011 0022 0002 6 6 612 0105
3 240 0011 0000 FFFD 7 7 71D 0106
3 340 1000 0000 FFF0 8 0 8F0 0107
3 0C0 1000 0022 0005 2 2 205 0108
3 004 0000 0000 0000 5 5 580 0109
3 000 0000 0000 0000 0 0 000 010A
3 000 0022 0000 0003 1 1 123 010B
3 200 0100 0200 0004 9 1 934 010C
3 240 0300 0011 0001 A 2 A91 010D
3 240 0011 0022 0002 A 2 A12 010E
0
